// File: dv/tile_video_model.svh
`ifndef TILE_VIDEO_MODEL_SVH
`define TILE_VIDEO_MODEL_SVH
`default_nettype none

//////////////////////////////////////////////////////////////////////
// reference model, mirrors of all cpu writes
//////////////////////////////////////////////////////////////////////

logic [2:0] m_pat [`PATTERN_WORDS];
logic [6:0] m_fg_map [`MAP_COLS * `MAP_ROWS];
logic [6:0] m_bg_map [`MAP_COLS * `MAP_ROWS];
// palette split like the bus bytes
logic [7:0] m_pal_gb [`PALETTE_BYTES / 2];
logic [3:0] m_pal_r [`PALETTE_BYTES / 2];
logic [5:0] m_bg_scroll;
logic m_prio;
logic [7:0] m_back;

// decode one write by the address map
function automatic void mirror_update(input logic [11:0] addr, input logic [7:0] data);
	if (addr < `REG_FG_MAP)
		m_pat[addr[9:0]] = data[2:0];
	else if (addr >= `REG_FG_MAP && addr < `REG_BG_MAP)
		m_fg_map[addr[3:0]] = data[6:0];
	else if (addr >= `REG_BG_MAP && addr < `REG_BG_MAP + 12'd16)
		m_bg_map[addr[3:0]] = data[6:0];
	else if (addr >= `REG_PALETTE && addr < `REG_PALETTE + 12'h200) begin
		// odd byte is red only
		if (addr[0])
			m_pal_r[addr[8:1]] = data[3:0];
		else
			m_pal_gb[addr[8:1]] = data;
	end else if (addr == `REG_BG_SCROLL)
		m_bg_scroll = data[5:0];
	else if (addr == `REG_PRIORITY)
		m_prio = data[0];
	else if (addr == `REG_BACKCOLOR)
		m_back = data;
endfunction

// tile slot, row major, 8 columns per map row
function automatic logic [3:0] map_slot(input int x, input int y);
	return 4'((y / 8) * `MAP_COLS + (x / 8));
endfunction

// pattern pixel: 64 pens per tile, 8 per row
function automatic logic [9:0] pattern_addr(input logic [3:0] code, input int x, input int y);
	return 10'(int'(code) * 64 + (y % 8) * 8 + (x % 8));
endfunction

// colour of visible pixel x, y as {r, g, b}
function automatic logic [11:0] predict_rgb(input int x, input int y);
	int bx;
	logic [6:0] fe;
	logic [6:0] be;
	logic [2:0] fp;
	logic [2:0] bp;
	logic [7:0] fg_idx;
	logic [7:0] bg_idx;
	logic [7:0] idx;
	// background shifted left by scroll, 64 pixel wrap
	bx = (x + int'(m_bg_scroll)) % (`MAP_COLS * 8);
	fe = m_fg_map[map_slot(x, y)];
	be = m_bg_map[map_slot(bx, y)];
	fp = m_pat[pattern_addr(fe[3:0], x, y)];
	bp = m_pat[pattern_addr(be[3:0], bx, y)];
	fg_idx = {2'd0, fe[6:4], fp};
	bg_idx = {2'd1, be[6:4], bp};
	idx = m_back;
	// front layer first, pen 0 lets the other through
	if (m_prio) begin
		if (bp != 3'd0)
			idx = bg_idx;
		else if (fp != 3'd0)
			idx = fg_idx;
	end else begin
		if (fp != 3'd0)
			idx = fg_idx;
		else if (bp != 3'd0)
			idx = bg_idx;
	end
	return {m_pal_r[idx], m_pal_gb[idx]};
endfunction

// one bus write per clk, driven on the falling edge
task automatic cpu_write(input logic [11:0] addr, input logic [7:0] data);
	@(negedge clk);
	cpu_addr = addr;
	cpu_data = data;
	cpu_we = 1'b1;
	mirror_update(addr, data);
endtask

task automatic cpu_release();
	@(negedge clk);
	cpu_we = 1'b0;
endtask

`default_nettype wire
`endif

// File: dv/tile_video_tb.sv
`timescale 1ns/1ps
`include "tile_video_settings.svh"
`default_nettype none

module tile_video_tb;

	localparam int NUM_ROWS = 6;
	localparam int FRAME_PIX = `H_TOTAL * `V_TOTAL;
	localparam int WAIT_LIMIT = 2 * FRAME_PIX * `PIX_DIV;
	// tile code kept all pen 0
	localparam logic [3:0] EMPTY_CODE = 4'hF;

	logic clk;
	logic rst_n;
	logic [11:0] cpu_addr;
	logic [7:0] cpu_data;
	logic cpu_we;
	wire [3:0] red;
	wire [3:0] green;
	wire [3:0] blue;
	wire hsync_n;
	wire vsync_n;
	wire hblank_n;
	wire vblank_n;

	integer seed;
	logic [7:0] fg_map_init [`MAP_COLS * `MAP_ROWS];

	// stimulus table
	string t_name [NUM_ROWS];
	logic [5:0] t_scroll [NUM_ROWS];
	logic t_prio [NUM_ROWS];
	logic [7:0] t_back [NUM_ROWS];
	logic t_fg_blank [NUM_ROWS];

	`include "tile_video_model.svh"

	tile_video uut (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.cpu_we(cpu_we),
		.red(red),
		.green(green),
		.blue(blue),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.hblank_n(hblank_n),
		.vblank_n(vblank_n)
	);

	// 100 ns clk
	always #50 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// checking
	//////////////////////////////////////////////////////////////////////

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input string what, input int expected,
			input int actual);
		assert (expected == actual) else
			stop_with_error($sformatf("Error: %s, %s, expected 0x%03h, actual 0x%03h",
				test, what, expected, actual));
	endtask

	// syncs high, blanks low, black
	task automatic check_reset_outputs(input string when);
		check_value("reset", {"hsync_n ", when}, 1, int'(hsync_n));
		check_value("reset", {"vsync_n ", when}, 1, int'(vsync_n));
		check_value("reset", {"hblank_n ", when}, 0, int'(hblank_n));
		check_value("reset", {"vblank_n ", when}, 0, int'(vblank_n));
		check_value("reset", {"rgb ", when}, 0, int'({red, green, blue}));
	endtask

	// reset state holds every clk until the first frame starts
	task automatic watch_until_first_frame();
		int n;
		n = 0;
		while (vblank_n !== 1'b1 && n < WAIT_LIMIT) begin
			check_reset_outputs("after reset");
			@(negedge clk);
			n++;
		end
		assert (vblank_n === 1'b1) else
			stop_with_error("timed out waiting for the first frame after reset");
	endtask

	task automatic wait_vblank(input logic level);
		int n;
		n = 0;
		while (vblank_n !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		assert (vblank_n === level) else
			stop_with_error($sformatf("timed out waiting for vblank_n to become %0b", level));
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic load_table();
		t_name[0] = "fg_over_bg";
		t_name[1] = "bg_scroll_5";
		t_name[2] = "bg_scroll_61";
		t_name[3] = "bg_in_front";
		t_name[4] = "bg_front_scroll_61";
		t_name[5] = "fg_blank_fallback";
		t_scroll = '{6'd0, 6'd5, 6'd61, 6'd0, 6'd61, 6'd5};
		t_prio = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
		t_back = '{8'h3c, 8'h3c, 8'h91, 8'h5a, 8'h5a, 8'hc7};
		t_fg_blank = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	endtask

	// random pattern, maps and palette
	task automatic fill_memories();
		integer r;
		logic [2:0] pen;
		for (int a = 0; a < `PATTERN_WORDS; a++) begin
			r = $random(seed);
			// pen 0 about half the time so the fallbacks show up
			pen = r[3] ? r[2:0] : 3'd0;
			if (a / 64 == int'(EMPTY_CODE))
				pen = 3'd0;
			cpu_write(`REG_PATTERN + 12'(a), {r[15:11], pen});
		end
		for (int k = 0; k < `MAP_COLS * `MAP_ROWS; k++) begin
			r = $random(seed);
			fg_map_init[k] = r[7:0];
			cpu_write(`REG_FG_MAP + 12'(k), r[7:0]);
			r = $random(seed);
			cpu_write(`REG_BG_MAP + 12'(k), r[7:0]);
		end
		for (int b = 0; b < `PALETTE_BYTES; b++) begin
			r = $random(seed);
			cpu_write(`REG_PALETTE + 12'(b), r[7:0]);
		end
		cpu_release();
	endtask

	// registers and foreground map written in vertical blanking
	task automatic apply_row(input int row);
		integer r;
		wait_vblank(1'b1);
		wait_vblank(1'b0);
		cpu_write(`REG_BG_SCROLL, {2'b00, t_scroll[row]});
		cpu_write(`REG_PRIORITY, {7'd0, t_prio[row]});
		cpu_write(`REG_BACKCOLOR, t_back[row]);
		for (int k = 0; k < `MAP_COLS * `MAP_ROWS; k++) begin
			r = $random(seed);
			if (t_fg_blank[row])
				cpu_write(`REG_FG_MAP + 12'(k), {1'b0, r[6:4], EMPTY_CODE});
			else
				cpu_write(`REG_FG_MAP + 12'(k), fg_map_init[k]);
		end
		cpu_release();
	endtask

	// one frame sampled once per pixel from the first visible pixel on
	task automatic capture_frame(input int row);
		int p;
		int x;
		int y;
		int hs_pulses;
		int vs_pulses;
		logic vis;
		logic prev_vis;
		logic prev_hs;
		logic prev_vs;
		logic [11:0] exp_rgb;
		logic [11:0] got_rgb;
		x = 0;
		y = 0;
		hs_pulses = 0;
		vs_pulses = 0;
		prev_vis = 1'b0;
		prev_hs = 1'b1;
		prev_vs = 1'b1;
		wait_vblank(1'b1);
		for (p = 0; p < FRAME_PIX; p++) begin
			if (p != 0)
				repeat (`PIX_DIV) @(negedge clk);
			vis = hblank_n && vblank_n;
			got_rgb = {red, green, blue};
			if (vis) begin
				exp_rgb = predict_rgb(x, y);
				check_value(t_name[row], $sformatf("rgb at x %0d y %0d", x, y),
					int'(exp_rgb), int'(got_rgb));
				x++;
			end else begin
				check_value(t_name[row], "rgb in blanking", 0, int'(got_rgb));
				// end of a visible line
				if (prev_vis) begin
					check_value(t_name[row], $sformatf("pixels on line %0d", y),
						`H_ACTIVE, x);
					x = 0;
					y++;
				end
			end
			if (prev_hs && !hsync_n)
				hs_pulses++;
			if (prev_vs && !vsync_n)
				vs_pulses++;
			prev_vis = vis;
			prev_hs = hsync_n;
			prev_vs = vsync_n;
		end
		check_value(t_name[row], "visible lines", `V_ACTIVE, y);
		check_value(t_name[row], "hsync pulses", `V_TOTAL, hs_pulses);
		check_value(t_name[row], "vsync pulses", 1, vs_pulses);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed = 77256;
		clk = 1'b0;
		rst_n = 1'b0;
		cpu_addr = '0;
		cpu_data = '0;
		cpu_we = 1'b0;
		// same values the DUT registers reset to
		m_bg_scroll = '0;
		m_prio = 1'b0;
		m_back = '0;
		load_table();
		repeat (3) begin
			@(negedge clk);
			check_reset_outputs("in reset");
		end
		rst_n = 1'b1;
		@(negedge clk);
		watch_until_first_frame();
		fill_memories();
		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(i);
			capture_frame(i);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/layer_mixer.sv
`timescale 1ns/1ps
`include "tile_video_settings.svh"
`default_nettype none

module layer_mixer (
	input wire clk,
	input wire rst_n,
	input wire pix_en,
	input wire [11:0] cpu_addr,
	input wire [7:0] cpu_data,
	input wire cpu_we,
	input wire [2:0] fg_pen,
	input wire [2:0] fg_palette,
	input wire [2:0] bg_pen,
	input wire [2:0] bg_palette,
	input wire [3:0] sync_in,
	output tile_video_pkg::dot_word_u dot,
	output logic [3:0] sync_out
);

	import tile_video_pkg::*;

	logic bg_front;
	logic [7:0] back_color;
	logic fg_opaque;
	logic bg_opaque;
	tile_dot_t fg_dot;
	tile_dot_t bg_dot;
	dot_word_u dot_next;

	//////////////////////////////////////////////////////////////////////
	// control registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bg_front <= 1'b0;
			back_color <= '0;
		end else if (cpu_we) begin
			// bit 0 puts background in front
			if (cpu_addr == `REG_PRIORITY)
				bg_front <= cpu_data[0];
			if (cpu_addr == `REG_BACKCOLOR)
				back_color <= cpu_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// priority and transparency
	//////////////////////////////////////////////////////////////////////

	// pen 0 is see-through
	assign fg_opaque = (fg_pen != 3'd0);
	assign bg_opaque = (bg_pen != 3'd0);

	always_comb begin
		fg_dot = '{bank: 2'd0, palette: fg_palette, pen: fg_pen};
		bg_dot = '{bank: 2'd1, palette: bg_palette, pen: bg_pen};
	end

	// flat back colour unless a layer wins
	always_comb begin
		dot_next.index = back_color;
		if (bg_front) begin
			if (bg_opaque)
				dot_next.tile = bg_dot;
			else if (fg_opaque)
				dot_next.tile = fg_dot;
		end else begin
			if (fg_opaque)
				dot_next.tile = fg_dot;
			else if (bg_opaque)
				dot_next.tile = bg_dot;
		end
	end

	always_ff @(posedge clk) begin
		if (pix_en)
			dot <= dot_next;
	end

	// third stage of the sync delay
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sync_out <= 4'b1100;
		else if (pix_en)
			sync_out <= sync_in;
	end

endmodule

`default_nettype wire

// File: hdl/palette_lookup.sv
`timescale 1ns/1ps
`include "tile_video_settings.svh"
`default_nettype none

module palette_lookup (
	input wire clk,
	input wire rst_n,
	input wire pix_en,
	input wire [11:0] cpu_addr,
	input wire [7:0] cpu_data,
	input wire cpu_we,
	input wire tile_video_pkg::dot_word_u dot,
	input wire [3:0] sync_in,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue,
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank_n,
	output logic vblank_n
);

	localparam int PAL_AW = $clog2(`PALETTE_BYTES);
	localparam int PAL_WORDS = `PALETTE_BYTES / 2;
	localparam logic [11:0] PAL_BASE = `REG_PALETTE;

	// even byte green [7:4] blue [3:0]
	logic [7:0] pal_gb [PAL_WORDS];
	// odd byte red in low nibble
	logic [3:0] pal_r [PAL_WORDS];

	logic pal_hit;
	logic [PAL_AW-2:0] wr_idx;
	logic [7:0] idx;
	logic visible;

	//////////////////////////////////////////////////////////////////////
	// palette ram, byte halves
	//////////////////////////////////////////////////////////////////////

	assign pal_hit = cpu_we && (cpu_addr[11:PAL_AW] == PAL_BASE[11:PAL_AW]);
	assign wr_idx = cpu_addr[PAL_AW-1:1];

	always_ff @(posedge clk) begin
		if (pal_hit) begin
			if (cpu_addr[0])
				pal_r[wr_idx] <= cpu_data[3:0];
			else
				pal_gb[wr_idx] <= cpu_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// lookup and output register
	//////////////////////////////////////////////////////////////////////

	// mixer fields read back as one flat index
	assign idx = dot.index;
	// both delayed blanks high
	assign visible = sync_in[1] && sync_in[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			red <= '0;
			green <= '0;
			blue <= '0;
			hsync_n <= 1'b1;
			vsync_n <= 1'b1;
			hblank_n <= 1'b0;
			vblank_n <= 1'b0;
		end else if (pix_en) begin
			// black in blanking
			red <= visible ? pal_r[idx] : 4'd0;
			green <= visible ? pal_gb[idx][7:4] : 4'd0;
			blue <= visible ? pal_gb[idx][3:0] : 4'd0;
			{hsync_n, vsync_n, hblank_n, vblank_n} <= sync_in;
		end
	end

endmodule

`default_nettype wire

// File: hdl/tile_layer_fetch.sv
`timescale 1ns/1ps
`include "tile_video_settings.svh"
`default_nettype none

module tile_layer_fetch #(
	parameter int LAYER_ID = 0
) (
	input wire clk,
	input wire rst_n,
	input wire pix_en,
	input wire [5:0] hpos,
	input wire [4:0] vpos,
	input wire [11:0] cpu_addr,
	input wire [7:0] cpu_data,
	input wire cpu_we,
	input wire [3:0] sync_in,
	output logic [2:0] pen,
	output logic [2:0] palette,
	output logic [3:0] sync_out
);

	localparam int MAP_WORDS = `MAP_COLS * `MAP_ROWS;
	localparam int MAP_AW = $clog2(MAP_WORDS);
	localparam int COL_W = $clog2(`MAP_COLS);
	localparam int ROW_W = $clog2(`MAP_ROWS);
	localparam int PAT_AW = $clog2(`PATTERN_WORDS);
	localparam logic [11:0] PAT_BASE = `REG_PATTERN;
	localparam logic [11:0] MAP_BASE = (LAYER_ID == 0) ? `REG_FG_MAP : `REG_BG_MAP;
	localparam logic [11:0] SCROLL_ADDR = (LAYER_ID == 0) ? `REG_FG_SCROLL : `REG_BG_SCROLL;

	// map entry is palette in [6:4], code in [3:0]
	logic [6:0] map_ram [MAP_WORDS];
	// pattern word is one 3 bit pen, addr {code, row, col}
	logic [2:0] pat_ram [`PATTERN_WORDS];

	logic [5:0] scroll;
	logic pat_hit;
	logic map_hit;
	logic scroll_hit;
	logic [5:0] x_scr;
	logic [MAP_AW-1:0] map_idx;
	logic [6:0] ent_q;
	logic [2:0] row_q;
	logic [2:0] col_q;
	logic [3:0] sync_d1;

	//////////////////////////////////////////////////////////////////////
	// cpu writes
	//////////////////////////////////////////////////////////////////////

	// every layer takes all pattern writes
	assign pat_hit = cpu_we && (cpu_addr[11:PAT_AW] == PAT_BASE[11:PAT_AW]);
	// own map and scroll only
	assign map_hit = cpu_we && (cpu_addr[11:MAP_AW] == MAP_BASE[11:MAP_AW]);
	assign scroll_hit = cpu_we && (cpu_addr == SCROLL_ADDR);

	always_ff @(posedge clk) begin
		if (pat_hit)
			pat_ram[cpu_addr[PAT_AW-1:0]] <= cpu_data[2:0];
	end

	// bit 7 of a map byte is dropped
	always_ff @(posedge clk) begin
		if (map_hit)
			map_ram[cpu_addr[MAP_AW-1:0]] <= cpu_data[6:0];
	end

	// only 64 pixels of map, so 6 bits of scroll
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			scroll <= '0;
		else if (scroll_hit)
			scroll <= cpu_data[5:0];
	end

	//////////////////////////////////////////////////////////////////////
	// stage 1, map entry
	//////////////////////////////////////////////////////////////////////

	// wraps modulo 64 by width
	assign x_scr = hpos + scroll;
	assign map_idx = {vpos[3 +: ROW_W], x_scr[3 +: COL_W]};

	always_ff @(posedge clk) begin
		if (pix_en) begin
			ent_q <= map_ram[map_idx];
			row_q <= vpos[2:0];
			col_q <= x_scr[2:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stage 2, pattern pen
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (pix_en) begin
			pen <= pat_ram[{ent_q[3:0], row_q, col_q}];
			palette <= ent_q[6:4];
		end
	end

	// two strobe delay for {hsync_n, vsync_n, hblank_n, vblank_n}
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_d1 <= 4'b1100;
			sync_out <= 4'b1100;
		end else if (pix_en) begin
			sync_d1 <= sync_in;
			sync_out <= sync_d1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/tile_video.sv
`timescale 1ns/1ps
`default_nettype none

module tile_video (
	input wire clk,
	input wire rst_n,
	input wire [11:0] cpu_addr,
	input wire [7:0] cpu_data,
	input wire cpu_we,
	output wire [3:0] red,
	output wire [3:0] green,
	output wire [3:0] blue,
	output wire hsync_n,
	output wire vsync_n,
	output wire hblank_n,
	output wire vblank_n
);

	import tile_video_pkg::*;

	// raster side
	wire pix_en;
	wire [5:0] hpos;
	wire [4:0] vpos;
	wire tm_hsync_n;
	wire tm_vsync_n;
	wire tm_hblank_n;
	wire tm_vblank_n;

	// layer outputs, two strobes behind the counters
	wire [2:0] fg_pen;
	wire [2:0] fg_palette;
	wire [2:0] bg_pen;
	wire [2:0] bg_palette;
	wire [3:0] fetch_sync;

	// mixer outputs, three strobes behind
	dot_word_u mix_dot;
	wire [3:0] mix_sync;

	//////////////////////////////////////////////////////////////////////
	// timing
	//////////////////////////////////////////////////////////////////////

	video_timing timing (
		.clk(clk),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.hpos(hpos),
		.vpos(vpos),
		.hsync_n(tm_hsync_n),
		.vsync_n(tm_vsync_n),
		.hblank_n(tm_hblank_n),
		.vblank_n(tm_vblank_n)
	);

	//////////////////////////////////////////////////////////////////////
	// tile layers
	//////////////////////////////////////////////////////////////////////

	// foreground carries the sync delay on
	tile_layer_fetch #(
		.LAYER_ID(0)
	) fg_layer (
		.clk(clk),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.hpos(hpos),
		.vpos(vpos),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.cpu_we(cpu_we),
		.sync_in({tm_hsync_n, tm_vsync_n, tm_hblank_n, tm_vblank_n}),
		.pen(fg_pen),
		.palette(fg_palette),
		.sync_out(fetch_sync)
	);

	// same delay, copy not needed
	tile_layer_fetch #(
		.LAYER_ID(1)
	) bg_layer (
		.clk(clk),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.hpos(hpos),
		.vpos(vpos),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.cpu_we(cpu_we),
		.sync_in({tm_hsync_n, tm_vsync_n, tm_hblank_n, tm_vblank_n}),
		.pen(bg_pen),
		.palette(bg_palette),
		.sync_out()
	);

	//////////////////////////////////////////////////////////////////////
	// mix and colour
	//////////////////////////////////////////////////////////////////////

	layer_mixer mixer (
		.clk(clk),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.cpu_we(cpu_we),
		.fg_pen(fg_pen),
		.fg_palette(fg_palette),
		.bg_pen(bg_pen),
		.bg_palette(bg_palette),
		.sync_in(fetch_sync),
		.dot(mix_dot),
		.sync_out(mix_sync)
	);

	palette_lookup palette (
		.clk(clk),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.cpu_we(cpu_we),
		.dot(mix_dot),
		.sync_in(mix_sync),
		.red(red),
		.green(green),
		.blue(blue),
		.hsync_n(hsync_n),
		.vsync_n(vsync_n),
		.hblank_n(hblank_n),
		.vblank_n(vblank_n)
	);

endmodule

`default_nettype wire

// File: hdl/tile_video_pkg.sv
`default_nettype none

package tile_video_pkg;

	//////////////////////////////////////////////////////////////////////
	// dot word between mixer and palette
	//////////////////////////////////////////////////////////////////////

	// one layer pixel as fields
	// bank 0 is the foreground, bank 1 the background
	typedef struct packed {
		logic [1:0] bank;
		logic [2:0] palette;
		logic [2:0] pen;
	} tile_dot_t;

	// same 8 bits seen as a flat palette index
	// back colour is written straight into index
	typedef union packed {
		tile_dot_t tile;
		logic [7:0] index;
	} dot_word_u;

endpackage

`default_nettype wire

// File: hdl/tile_video_settings.svh
`ifndef TILE_VIDEO_SETTINGS_SVH
`define TILE_VIDEO_SETTINGS_SVH
`default_nettype none

// raster, in pixels and lines
`define H_TOTAL 48
`define H_ACTIVE 32
`define H_SYNC_START 36
`define H_SYNC_END 40
`define V_TOTAL 24
`define V_ACTIVE 16
`define V_SYNC_START 18
`define V_SYNC_END 20

// clk cycles per pixel strobe
`define PIX_DIV 4

// tilemap per layer, 8x8 pixel tiles, wraps at 64 pixels
`define MAP_COLS 8
`define MAP_ROWS 2
`define PATTERN_WORDS 1024
`define PALETTE_BYTES 512

// cpu write regions
`define REG_PATTERN 12'h000
`define REG_FG_MAP 12'h400
`define REG_BG_MAP 12'h410
`define REG_PALETTE 12'h800
`define REG_FG_SCROLL 12'hF00
`define REG_BG_SCROLL 12'hF01
`define REG_PRIORITY 12'hF02
`define REG_BACKCOLOR 12'hF03

`default_nettype wire
`endif

// File: hdl/video_timing.sv
`timescale 1ns/1ps
`include "tile_video_settings.svh"
`default_nettype none

module video_timing (
	input wire clk,
	input wire rst_n,
	output logic pix_en,
	output logic [5:0] hpos,
	output logic [4:0] vpos,
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank_n,
	output logic vblank_n
);

	localparam int DIV_W = $clog2(`PIX_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`PIX_DIV - 1);
	localparam logic [5:0] H_LAST = 6'(`H_TOTAL - 1);
	localparam logic [5:0] H_ACT = 6'(`H_ACTIVE);
	localparam logic [5:0] H_SYNC_ON = 6'(`H_SYNC_START);
	localparam logic [5:0] H_SYNC_OFF = 6'(`H_SYNC_END);
	localparam logic [4:0] V_LAST = 5'(`V_TOTAL - 1);
	localparam logic [4:0] V_ACT = 5'(`V_ACTIVE);
	localparam logic [4:0] V_SYNC_ON = 5'(`V_SYNC_START);
	localparam logic [4:0] V_SYNC_OFF = 5'(`V_SYNC_END);

	logic [DIV_W-1:0] div_cnt;
	logic div_wrap;
	logic [5:0] h_next;
	logic [4:0] v_next;

	//////////////////////////////////////////////////////////////////////
	// pixel strobe
	//////////////////////////////////////////////////////////////////////

	assign div_wrap = (div_cnt == DIV_LAST);

	// pix_en rises on the same edge the counters step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			pix_en <= 1'b0;
		end else begin
			div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
			pix_en <= div_wrap;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// raster counters
	//////////////////////////////////////////////////////////////////////

	// next position, vertical steps at end of line
	always_comb begin
		h_next = hpos + 6'd1;
		v_next = vpos;
		if (hpos == H_LAST) begin
			h_next = '0;
			v_next = (vpos == V_LAST) ? '0 : vpos + 5'd1;
		end
	end

	// syncs and blanks compared on the next position
	// so they line up with hpos and vpos
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hpos <= '0;
			vpos <= '0;
			hsync_n <= 1'b1;
			vsync_n <= 1'b1;
			hblank_n <= 1'b0;
			vblank_n <= 1'b0;
		end else if (div_wrap) begin
			hpos <= h_next;
			vpos <= v_next;
			hblank_n <= (h_next < H_ACT);
			vblank_n <= (v_next < V_ACT);
			hsync_n <= !((h_next >= H_SYNC_ON) && (h_next < H_SYNC_OFF));
			vsync_n <= !((v_next >= V_SYNC_ON) && (v_next < V_SYNC_OFF));
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# compile with verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tile_video_tb -f tile_video.f \
	&& ./obj_dir/Vtile_video_tb > "$log" 2>&1 \
	|| echo "build or simulation stopped with an error"

cat "$log" 2>/dev/null

grep -qx "Simulation passed" "$log" 2>/dev/null && echo "PASS" && exit 0
echo "FAIL"
exit 1

// File: tile_video.f
+incdir+hdl
+incdir+dv
hdl/tile_video_pkg.sv
hdl/video_timing.sv
hdl/tile_layer_fetch.sv
hdl/layer_mixer.sv
hdl/palette_lookup.sv
hdl/tile_video.sv
dv/tile_video_tb.sv
